// File: rx_ctrl_config.svh
`ifndef RX_CTRL_CONFIG_SVH
`define RX_CTRL_CONFIG_SVH

// Sample word from the DSP side
`define RX_SAMPLE_W     32

// Buffer depths
`define RX_CMDQ_DEPTH   8
`define RX_LINEQ_DEPTH  16

// Wishbone word addresses
`define RX_REG_CMD      3'd0
`define RX_REG_TIME_HI  3'd1
`define RX_REG_TIME_LO  3'd2  // Write pushes the command
`define RX_REG_CLEAR    3'd3
`define RX_REG_STATUS   3'd4

`endif

// File: rx_ctrl_pkg.sv
`include "rx_ctrl_config.svh"

package rx_ctrl_pkg;

   localparam int RX_QCOUNT_W = $clog2(`RX_CMDQ_DEPTH + 1);

   typedef logic [RX_QCOUNT_W-1:0] rx_qcount_t;

   typedef struct packed {
      logic        send_imm;
      logic        chain;
      logic [29:0] num_lines;
      logic [63:0] trigger_time;
   } rx_cmd_t;

   typedef struct packed {
      logic overrun;
      logic broken_chain;
      logic late_cmd;
      logic cmd_done;
   } rx_flags_t;

   typedef struct packed {
      rx_flags_t               flags;
      logic [63:0]             timestamp;
      logic [`RX_SAMPLE_W-1:0] sample;
   } rx_line_t;

   // Codes 3 and 7 unused
   typedef enum logic [2:0] {
      IDLE         = 3'd0,
      WAITING      = 3'd1,
      RUNNING      = 3'd2,
      OVERRUN      = 3'd4,
      BROKEN_CHAIN = 3'd5,
      LATE_CMD     = 3'd6
   } rx_state_e;

endpackage

// File: rx_cmd_if.sv
`timescale 1ns/1ps

interface rx_cmd_if import rx_ctrl_pkg::*; ();

   logic       push;
   rx_cmd_t    push_cmd;
   logic       full;
   rx_cmd_t    head;      // Valid while empty is low
   logic       empty;
   logic       pop;
   logic       clear;     // One-cycle flush of both buffers
   rx_qcount_t count;

   modport wr (
      output push, push_cmd, clear,
      input  full, count
   );

   modport q (
      input  push, push_cmd, pop, clear,
      output full, head, empty, count
   );

   modport rd (
      input  head, empty, clear,
      output pop
   );

endinterface

// File: rx_cmd_regs.sv
`timescale 1ns/1ps
`include "rx_ctrl_config.svh"

module rx_cmd_regs import rx_ctrl_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n_i,
   input  logic        wb_cyc_i,
   input  logic        wb_stb_i,
   input  logic        wb_we_i,
   input  logic [2:0]  wb_adr_i,
   input  logic [31:0] wb_dat_i,
   output logic [31:0] wb_dat_o,
   output logic        wb_ack_o,
   input  rx_state_e   state_i,
   rx_cmd_if.wr        cmd
);

   logic [31:0] cmd_word;   // {send_imm, chain, num_lines}
   logic [31:0] time_hi;
   logic [31:0] time_lo;
   logic        bus_req;
   logic        bus_wr;
   logic        push_q;
   logic        clear_q;
   logic [31:0] status;
   logic [31:0] rd_data;

   // Request beat only, so ack drops even if the master keeps stb high
   assign bus_req = wb_cyc_i && wb_stb_i && !wb_ack_o;
   assign bus_wr  = bus_req && wb_we_i;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wb_ack_o <= 1'b0;
         push_q   <= 1'b0;
         clear_q  <= 1'b0;
      end
      else
      begin
         wb_ack_o <= bus_req;
         push_q   <= bus_wr && (wb_adr_i == `RX_REG_TIME_LO);
         clear_q  <= bus_wr && (wb_adr_i == `RX_REG_CLEAR);
      end
   end

   always_ff @(posedge clk)
   begin
      if (bus_wr)
      begin
         case (wb_adr_i)
            `RX_REG_CMD:     cmd_word <= wb_dat_i;
            `RX_REG_TIME_HI: time_hi  <= wb_dat_i;
            `RX_REG_TIME_LO: time_lo  <= wb_dat_i;
            default: ;
         endcase
      end
      if (bus_req)
         wb_dat_o <= rd_data;  // Presented on the ack beat
   end

   always_comb
   begin
      status      = '0;
      status[3:0] = 4'(cmd.count);
      status[6:4] = state_i;
      case (wb_adr_i)
         `RX_REG_CMD:     rd_data = cmd_word;
         `RX_REG_TIME_HI: rd_data = time_hi;
         `RX_REG_TIME_LO: rd_data = time_lo;
         `RX_REG_STATUS:  rd_data = status;
         default:         rd_data = '0;
      endcase
   end

   // Push lands on the ack beat, words already updated
   assign cmd.push     = push_q && !cmd.full;
   assign cmd.push_cmd = '{send_imm:     cmd_word[31],
                           chain:        cmd_word[30],
                           num_lines:    cmd_word[29:0],
                           trigger_time: {time_hi, time_lo}};
   assign cmd.clear    = clear_q;

endmodule

// File: rx_cmd_queue.sv
`timescale 1ns/1ps
`include "rx_ctrl_config.svh"

module rx_cmd_queue import rx_ctrl_pkg::*;
#(
   parameter int DEPTH = `RX_CMDQ_DEPTH
)
(
   input logic clk,
   input logic rst_n_i,
   rx_cmd_if.q cmd
);

   localparam int PTR_W = $clog2(DEPTH);

   rx_cmd_t          mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             do_push;
   logic             do_pop;

   assign cmd.full  = (cmd.count == RX_QCOUNT_W'(DEPTH));
   assign cmd.empty = (cmd.count == '0);
   assign cmd.head  = mem[rd_ptr];  // Fall-through head

   assign do_push = cmd.push && !cmd.full;
   assign do_pop  = cmd.pop && !cmd.empty;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         cmd.count <= '0;
      end
      else if (cmd.clear)
      begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         cmd.count <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (do_push && !do_pop)
            cmd.count <= cmd.count + 1'b1;
         else if (do_pop && !do_push)
            cmd.count <= cmd.count - 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= cmd.push_cmd;
   end

endmodule

// File: rx_sample_ctrl.sv
`timescale 1ns/1ps
`include "rx_ctrl_config.svh"

module rx_sample_ctrl import rx_ctrl_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  logic [63:0]             time_i,
   input  logic [`RX_SAMPLE_W-1:0] sample_i,
   input  logic                    strobe_i,
   input  logic                    space_i,
   rx_cmd_if.rd                    cmd,
   output logic                    wr_o,
   output rx_line_t                line_o,
   output rx_state_e               state_o,
   output logic                    run_o,
   output logic                    overrun_o
);

   rx_state_e   state;
   logic [29:0] lines_left;
   logic [63:0] trig_time;
   logic        send_imm;
   logic        chain;
   logic        go_now;
   logic        too_late;
   logic        take;
   logic        last;
   logic        chain_next;
   logic        load;
   logic        err_state;

   assign go_now   = send_imm || (time_i == trig_time);
   assign too_late = !send_imm && (time_i > trig_time);

   assign take       = run_o && strobe_i && space_i;  // Sample accepted this cycle
   assign last       = take && (lines_left == 30'd1);
   assign chain_next = last && chain && !cmd.empty;
   assign load       = ((state == IDLE) && !cmd.empty) || chain_next;
   assign cmd.pop    = load && !cmd.clear;

   assign err_state = (state == OVERRUN) || (state == BROKEN_CHAIN) || (state == LATE_CMD);
   assign wr_o      = take || (err_state && space_i);

   assign state_o   = state;
   assign run_o     = (state == RUNNING);
   assign overrun_o = (state == OVERRUN);

   always_comb
   begin
      line_o.flags.overrun      = (state == OVERRUN);
      line_o.flags.broken_chain = (state == BROKEN_CHAIN);
      line_o.flags.late_cmd     = (state == LATE_CMD);
      // A zero-length follow-up also ends the run here
      line_o.flags.cmd_done     = last && (!chain || (!cmd.empty && cmd.head.num_lines == '0));
      line_o.timestamp          = time_i;
      line_o.sample             = run_o ? sample_i : '0;  // Flag lines carry no sample
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state      <= IDLE;
         lines_left <= '0;
      end
      else if (cmd.clear)
      begin
         state      <= IDLE;
         lines_left <= '0;
      end
      else
      begin
         case (state)
            IDLE:
               if (!cmd.empty)
               begin
                  state      <= WAITING;
                  lines_left <= cmd.head.num_lines;
               end
            WAITING:
               if (go_now)
                  state <= RUNNING;
               else if (too_late)
                  state <= LATE_CMD;
            RUNNING:
               if (strobe_i && !space_i)
                  state <= OVERRUN;
               else if (take)
               begin
                  lines_left <= lines_left - 1'b1;
                  if (last)
                  begin
                     if (!chain)
                        state <= IDLE;
                     else if (cmd.empty)
                        state <= BROKEN_CHAIN;
                     else
                     begin
                        lines_left <= cmd.head.num_lines;  // Seamless into next command
                        if (cmd.head.num_lines == '0)
                           state <= IDLE;
                     end
                  end
               end
            default:
               if (space_i)
                  state <= IDLE;  // Flag line written this cycle
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (load)
      begin
         trig_time <= cmd.head.trigger_time;
         send_imm  <= cmd.head.send_imm;
         chain     <= cmd.head.chain;
      end
   end

endmodule

// File: rx_sample_fifo.sv
`timescale 1ns/1ps
`include "rx_ctrl_config.svh"

module rx_sample_fifo import rx_ctrl_pkg::*;
#(
   parameter int DEPTH = `RX_LINEQ_DEPTH
)
(
   input  logic     clk,
   input  logic     rst_n_i,
   input  logic     clear_i,
   input  logic     wr_i,
   input  rx_line_t line_i,
   input  logic     ready_i,
   output logic     space_o,
   output rx_line_t line_o,
   output logic     valid_o
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   rx_line_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_wr;
   logic             do_rd;

   assign space_o = (count != CNT_W'(DEPTH));
   assign valid_o = (count != '0);
   assign line_o  = mem[rd_ptr];

   assign do_wr = wr_i && space_o;
   assign do_rd = valid_o && ready_i;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else if (clear_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (do_wr && !do_rd)
            count <= count + 1'b1;
         else if (do_rd && !do_wr)
            count <= count - 1'b1;
      end
   end

   // Never overwrites the head, writes need space
   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= line_i;
   end

endmodule

// File: rx_ctrl_top.sv
`timescale 1ns/1ps
`include "rx_ctrl_config.svh"

module rx_ctrl_top import rx_ctrl_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  logic                    wb_cyc_i,
   input  logic                    wb_stb_i,
   input  logic                    wb_we_i,
   input  logic [2:0]              wb_adr_i,
   input  logic [31:0]             wb_dat_i,
   output logic [31:0]             wb_dat_o,
   output logic                    wb_ack_o,
   input  logic [63:0]             time_i,
   input  logic [`RX_SAMPLE_W-1:0] sample_i,
   input  logic                    strobe_i,
   output rx_line_t                line_o,
   output logic                    line_valid_o,
   input  logic                    line_ready_i,
   output logic                    run_o,
   output logic                    overrun_o
);

   rx_state_e state;
   logic      line_wr;
   rx_line_t  line_in;
   logic      space;

   rx_cmd_if cmd ();

   rx_cmd_regs u_regs (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_we_i  (wb_we_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .state_i  (state),
      .cmd      (cmd.wr)
   );

   rx_cmd_queue u_queue (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .cmd     (cmd.q)
   );

   rx_sample_ctrl u_ctrl (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .time_i    (time_i),
      .sample_i  (sample_i),
      .strobe_i  (strobe_i),
      .space_i   (space),
      .cmd       (cmd.rd),
      .wr_o      (line_wr),
      .line_o    (line_in),
      .state_o   (state),
      .run_o     (run_o),
      .overrun_o (overrun_o)
   );

   // Clear also flushes buffered lines
   rx_sample_fifo u_fifo (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .clear_i (cmd.clear),
      .wr_i    (line_wr),
      .line_i  (line_in),
      .ready_i (line_ready_i),
      .space_o (space),
      .line_o  (line_o),
      .valid_o (line_valid_o)
   );

endmodule

// File: rx_ctrl_assert.sv
`timescale 1ns/1ps

module rx_ctrl_assert import rx_ctrl_pkg::*;
(
   input logic     clk,
   input logic     rst_n_i,
   input logic     wb_cyc_i,
   input logic     wb_stb_i,
   input logic     wb_ack_o,
   input logic     run_o,
   input logic     overrun_o,
   input rx_line_t line_o,
   input logic     line_valid_o,
   input logic     line_ready_i
);

   ack_after_req: assert property (@(posedge clk) disable iff (!rst_n_i)
      wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
      else $error("Wishbone ack without a request");

   ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
      wb_ack_o |=> !wb_ack_o)
      else $error("Wishbone ack longer than one cycle");

   // Overrun only comes out of a running command
   run_vs_overrun: assert property (@(posedge clk) disable iff (!rst_n_i)
      overrun_o |-> !run_o && $past(run_o || overrun_o))
      else $error("overrun without a running command before it");

   // Clear may drop valid, otherwise the line holds
   line_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      line_valid_o && !line_ready_i |=> !line_valid_o || $stable(line_o))
      else $error("Output line changed while stalled");

endmodule

bind rx_ctrl_top rx_ctrl_assert u_assert (
   .clk          (clk),
   .rst_n_i      (rst_n_i),
   .wb_cyc_i     (wb_cyc_i),
   .wb_stb_i     (wb_stb_i),
   .wb_ack_o     (wb_ack_o),
   .run_o        (run_o),
   .overrun_o    (overrun_o),
   .line_o       (line_o),
   .line_valid_o (line_valid_o),
   .line_ready_i (line_ready_i)
);

// File: rx_ctrl_tb.sv
`timescale 1ns/1ps
`include "rx_ctrl_config.svh"

module rx_ctrl_tb import rx_ctrl_pkg::*;
();

   typedef struct {
      string      name;
      bit         send_imm;
      bit         chain;
      int         lines;
      longint     off;         // Trigger relative to the time at test start
      bit         follow;      // Queue an immediate unchained follow-up
      int         ready_mode;  // 1 holds ready low until overrun
      int         exp_lines;
      logic [3:0] exp_flags;   // {overrun, broken_chain, late_cmd, cmd_done}
   } test_row_t;

   logic                    clk;
   logic                    rst_n_i;
   logic                    wb_cyc_i;
   logic                    wb_stb_i;
   logic                    wb_we_i;
   logic [2:0]              wb_adr_i;
   logic [31:0]             wb_dat_i;
   logic [31:0]             wb_dat_o;
   logic                    wb_ack_o;
   logic [63:0]             time_i;
   logic [`RX_SAMPLE_W-1:0] sample_i;
   logic                    strobe_i;
   rx_line_t                line_o;
   logic                    line_valid_o;
   logic                    line_ready_i;
   logic                    run_o;
   logic                    overrun_o;

   test_row_t               rows [6];
   logic [`RX_SAMPLE_W-1:0] sample_hist [4096];  // Indexed by time bits 11:0
   integer                  seed = 32'h7738_c226;
   logic [63:0]             next_time;
   logic [`RX_SAMPLE_W-1:0] next_sample;
   int                      limit = 0;
   int                      cycle_cnt = 0;
   string                   cur_name;
   bit                      cur_imm;
   logic [63:0]             cur_trig;
   int                      cur_exp_lines;
   logic [3:0]              cur_exp_flags;
   int                      lines_seen;
   logic [63:0]             prev_ts;
   logic [3:0]              last_flags;
   int                      run_cycles = 0;
   int                      test_err = 0;
   int                      total_err = 0;
   int                      n_tests = 0;
   int                      n_failed = 0;
   logic [31:0]             rd_word;

   rx_ctrl_top UUT (.*);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Free-running time with a fresh sample every cycle
   always @(posedge clk)
   begin
      next_time   = time_i + 1;
      next_sample = $random(seed);
      sample_hist[next_time[11:0]] = next_sample;
      time_i   <= next_time;
      sample_i <= next_sample;
   end

   task automatic report_mismatch(input string what, input logic [63:0] exp_v,
                                  input logic [63:0] act_v);
      $display("** Error [%s] %s: expected %0h, actual %0h", cur_name, what, exp_v, act_v);
      test_err++;
      total_err++;
   endtask

   task automatic report_fault(input string msg);
      $display("Test %s went wrong: %s", cur_name, msg);
      test_err++;
      total_err++;
   endtask

   task automatic check_line(input rx_line_t ln);
      logic [3:0] exp_f;
      bit         flag_line;
      flag_line = ln.flags.overrun || ln.flags.broken_chain || ln.flags.late_cmd;
      if (lines_seen >= cur_exp_lines)
         assert (0) else report_fault("a line arrived beyond the expected count");
      else if (flag_line)
      begin
         assert (ln.flags == cur_exp_flags)
            else report_mismatch("flag line", cur_exp_flags, ln.flags);
         assert (lines_seen == cur_exp_lines - 1)
            else report_fault("a flag line arrived before the last data line");
      end
      else
      begin
         exp_f = (cur_exp_flags == 4'b0001 && lines_seen == cur_exp_lines - 1) ? 4'b0001 : 4'b0000;
         assert (ln.flags == exp_f) else report_mismatch("line flags", exp_f, ln.flags);
         assert (ln.sample == sample_hist[ln.timestamp[11:0]])
            else report_mismatch("sample", sample_hist[ln.timestamp[11:0]], ln.sample);
         if (lines_seen > 0)
            assert (ln.timestamp == prev_ts + 1)
               else report_mismatch("timestamp", prev_ts + 1, ln.timestamp);
         else if (!cur_imm)
            assert (ln.timestamp == cur_trig + 1)
               else report_mismatch("first timestamp", cur_trig + 1, ln.timestamp);
         prev_ts = ln.timestamp;
      end
      last_flags = ln.flags;
      lines_seen++;
   endtask

   // Transfer happens on the next rising edge
   always @(negedge clk)
   begin
      if (rst_n_i && line_valid_o && line_ready_i)
         check_line(line_o);
   end

   // Cycles spent in RUNNING during the current test
   always @(negedge clk)
   begin
      if (rst_n_i && run_o)
         run_cycles++;
   end

   task automatic bus_cycle(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
      @(posedge clk);
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      wb_we_i  <= we;
      wb_adr_i <= adr;
      wb_dat_i <= wdat;
      do
         @(negedge clk);
      while (!wb_ack_o);
      rdat = wb_dat_o;
      @(posedge clk);
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
   endtask

   task automatic send_cmd(input bit imm, input bit chain, input int lines,
                           input logic [63:0] trig);
      bus_cycle(1'b1, `RX_REG_CMD, {imm, chain, lines[29:0]}, rd_word);
      bus_cycle(1'b1, `RX_REG_TIME_HI, trig[63:32], rd_word);
      bus_cycle(1'b1, `RX_REG_TIME_LO, trig[31:0], rd_word);  // Pushes the command
   endtask

   task automatic start_test(input string name, input bit imm, input int n,
                             input logic [3:0] flags);
      cur_name      = name;
      cur_imm       = imm;
      cur_exp_lines = n;
      cur_exp_flags = flags;
      lines_seen    = 0;
      last_flags    = 4'b0000;
      test_err      = 0;
      run_cycles    = 0;
      @(negedge clk);
      cur_trig      = time_i;
   endtask

   task automatic finish_test();
      $display("Test %-13s lines %0d  errors %0d  %s", cur_name, lines_seen, test_err,
               (test_err == 0) ? "ok" : "failed");
      n_tests++;
      if (test_err != 0)
         n_failed++;
   endtask

   task automatic run_row(input test_row_t r);
      int exp_run;
      // One strobe per data line, the overrun strobe stands in for its flag line
      exp_run = r.exp_lines;
      if (r.exp_flags[2] || r.exp_flags[1])
         exp_run--;
      start_test(r.name, r.send_imm, r.exp_lines, r.exp_flags);
      cur_trig = cur_trig + r.off;
      if (r.ready_mode == 1)
      begin
         @(posedge clk);
         line_ready_i <= 1'b0;
      end
      send_cmd(r.send_imm, r.chain, r.lines, cur_trig);
      if (r.follow)
         send_cmd(1'b1, 1'b0, r.lines, 64'd0);
      if (r.ready_mode == 1)
      begin
         while (!overrun_o)
            @(negedge clk);
         @(posedge clk);
         line_ready_i <= 1'b1;
      end
      while (lines_seen < r.exp_lines)
         @(negedge clk);
      repeat (20) @(negedge clk);  // Catch stray lines
      assert (lines_seen == r.exp_lines)
         else report_mismatch("line count", r.exp_lines, lines_seen);
      assert (last_flags == r.exp_flags)
         else report_mismatch("final flags", r.exp_flags, last_flags);
      assert (run_cycles == exp_run)
         else report_mismatch("run cycles", exp_run, run_cycles);
      finish_test();
   endtask

   task automatic run_clear_test();
      start_test("clear", 1'b0, 0, 4'b0000);
      cur_trig = cur_trig + 80;
      repeat (3) send_cmd(1'b0, 1'b0, 4, cur_trig);  // First one waits, two stay queued
      bus_cycle(1'b0, `RX_REG_STATUS, 32'd0, rd_word);
      assert (rd_word == {25'd0, WAITING, 4'd2})
         else report_mismatch("status before clear", {25'd0, WAITING, 4'd2}, rd_word);
      bus_cycle(1'b1, `RX_REG_CLEAR, 32'd0, rd_word);
      bus_cycle(1'b0, `RX_REG_STATUS, 32'd0, rd_word);
      assert (rd_word == {25'd0, IDLE, 4'd0})
         else report_mismatch("status after clear", {25'd0, IDLE, 4'd0}, rd_word);
      while (time_i <= cur_trig + 10)
         @(negedge clk);
      assert (run_cycles == 0)
         else report_mismatch("run cycles", 0, run_cycles);
      finish_test();
   endtask

   function automatic int cycle_limit();
      int sum;
      sum = 300;  // Reset and clear test
      foreach (rows[i])
         sum += 2 * rows[i].lines + 100 + int'((rows[i].off < 0) ? -rows[i].off : rows[i].off);
      return sum;
   endfunction

   initial
   begin
      wait (limit > 0);
      while (cycle_cnt < limit)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout: the tests did not complete within %0d cycles", limit);
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial
   begin
      rst_n_i      = 1'b0;
      wb_cyc_i     = 1'b0;
      wb_stb_i     = 1'b0;
      wb_we_i      = 1'b0;
      wb_adr_i     = 3'd0;
      wb_dat_i     = 32'd0;
      strobe_i     = 1'b1;
      line_ready_i = 1'b1;
      time_i       = 64'h0000_0000_FFFF_FF00;  // Crosses into the high word
      sample_i     = $random(seed);
      sample_hist[time_i[11:0]] = sample_i;
      cur_name     = "reset";
      cur_exp_lines = 0;
      rows[0] = '{"imm_4",        1'b1, 1'b0, 4,  0,  1'b0, 0, 4,  4'b0001};
      rows[1] = '{"timed_3",      1'b0, 1'b0, 3,  30, 1'b0, 0, 3,  4'b0001};
      rows[2] = '{"late",         1'b0, 1'b0, 5,  -5, 1'b0, 0, 1,  4'b0010};
      rows[3] = '{"chain_follow", 1'b0, 1'b1, 4,  40, 1'b1, 0, 8,  4'b0001};
      rows[4] = '{"chain_broken", 1'b1, 1'b1, 3,  0,  1'b0, 0, 4,  4'b0100};
      rows[5] = '{"overrun",      1'b1, 1'b0, 20, 0,  1'b0, 1, 17, 4'b1000};
      limit = cycle_limit();
      repeat (5) @(posedge clk);
      rst_n_i <= 1'b1;
      repeat (3) @(posedge clk);
      foreach (rows[i])
         run_row(rows[i]);
      run_clear_test();
      $display("Tests run %0d, failed %0d, errors %0d", n_tests, n_failed, total_err);
      if (total_err == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// File: verilog.f
+incdir+.
rx_ctrl_pkg.sv
rx_cmd_if.sv
rx_cmd_regs.sv
rx_cmd_queue.sv
rx_sample_ctrl.sv
rx_sample_fifo.sv
rx_ctrl_top.sv
rx_ctrl_assert.sv
rx_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f verilog.f --top-module rx_ctrl_tb -o rx_ctrl_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/rx_ctrl_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
   exit 0
fi
exit 1
